// File: design/cache_pkg.sv
package cache_pkg;

    localparam int index_w = 4;
    localparam int tag_w = 8;
    localparam int addr_w = tag_w + index_w;
    localparam int data_w = 32;

    localparam int lines = 1 << index_w;
    localparam int mem_words = 1 << addr_w;

    // default memory response time, overridden from the top level
    localparam int mem_latency_dflt = 4;

    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
    } addr_t;

    // processor request, held until done
    typedef struct packed {
        logic              req;
        logic              we;
        addr_t             addr;
        logic [data_w-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              en;
        logic              rd;    // read when set
        addr_t             addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_cache       = 3'd1,
        st_miss        = 3'd2,
        st_writeback   = 3'd3,
        st_flush_start = 3'd4,
        st_flush_busy  = 3'd5
    } ctrl_state_t;

endpackage

// File: design/cache_controller.sv
`timescale 1ns/100ps

module cache_controller
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  cpu_req_t           cpu_req,
    input  logic               flush,
    input  logic               hit,
    input  logic               line_dirty,
    input  logic               done_mem,
    output logic               mem_en,
    output logic               mem_rd,
    output logic               fill,
    output logic               cpu_update,
    output logic               latch_victim,
    output logic               flush_clean,
    output logic               wb_sel,
    output logic [index_w-1:0] flush_index,
    output logic               idle,
    output logic               done,
    output logic               flush_done
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic [index_w-1:0] flush_cnt;
    logic               flush_clr;
    logic               flush_inc;
    logic               flush_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_cnt <= '0;
        end else if (flush_clr) begin
            flush_cnt <= '0;
        end else if (flush_inc) begin
            flush_cnt <= flush_cnt + 1'b1;
        end
    end

    assign flush_last = (flush_cnt == '1);
    assign flush_index = flush_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        mem_en = 1'b0;
        mem_rd = 1'b0;
        fill = 1'b0;
        cpu_update = 1'b0;
        latch_victim = 1'b0;
        flush_clean = 1'b0;
        wb_sel = 1'b0;
        idle = 1'b0;
        done = 1'b0;
        flush_done = 1'b0;
        flush_clr = 1'b0;
        flush_inc = 1'b0;

        case (state)
            st_idle: begin
                idle = 1'b1;
                if (flush) begin            // flush wins over a request
                    flush_clr = 1'b1;
                    next_state = st_flush_start;
                end else if (cpu_req.req) begin
                    if (hit) begin
                        cpu_update = 1'b1;
                        next_state = st_cache;
                    end else begin
                        latch_victim = 1'b1;  // save victim before the fill
                        next_state = st_miss;
                    end
                end
            end

            st_cache: begin
                done = 1'b1;
                next_state = st_idle;
            end

            st_miss: begin
                mem_en = 1'b1;
                mem_rd = 1'b1;
                if (done_mem) begin
                    fill = 1'b1;
                    done = 1'b1;
                    // victim goes back to memory after the fill
                    next_state = line_dirty ? st_writeback : st_idle;
                end
            end

            st_writeback: begin
                mem_en = 1'b1;   // write from eviction buffer
                if (done_mem) begin
                    next_state = st_idle;
                end
            end

            st_flush_start: begin
                wb_sel = 1'b1;
                if (line_dirty) begin
                    next_state = st_flush_busy;
                end else if (flush_last) begin
                    flush_done = 1'b1;
                    next_state = st_idle;
                end else begin
                    flush_inc = 1'b1;   // clean line, one cycle
                end
            end

            st_flush_busy: begin
                wb_sel = 1'b1;
                mem_en = 1'b1;
                if (done_mem) begin
                    flush_clean = 1'b1;
                    if (flush_last) begin
                        flush_done = 1'b1;
                        next_state = st_idle;
                    end else begin
                        flush_inc = 1'b1;
                        next_state = st_flush_start;
                    end
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // memory traffic out of idle needs a command
    a_mem_en_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(mem_en) && $past(state) == st_idle |-> $past(cpu_req.req || flush));

    a_done_excl: assert property (@(posedge clk) disable iff (!rst)
        !(done && flush_done));

endmodule

// File: design/cache_array.sv
`timescale 1ns/100ps

module cache_array
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  cpu_req_t           cpu_req,
    input  logic               fill,
    input  logic               cpu_update,
    input  logic               latch_victim,
    input  logic               flush_clean,
    input  logic               wb_sel,
    input  logic [index_w-1:0] flush_index,
    input  logic [data_w-1:0]  mem_rdata,
    output logic               hit,
    output logic               line_dirty,
    output addr_t              wb_addr,
    output logic [data_w-1:0]  wb_data,
    output logic [data_w-1:0]  rdata
);

    logic [tag_w-1:0]  tag_mem [lines];
    logic [data_w-1:0] data_mem [lines];
    logic [lines-1:0]  valid;
    logic [lines-1:0]  dirty;

    // eviction buffer
    addr_t             evict_addr;
    logic [data_w-1:0] evict_data;
    logic              evict_dirty;

    logic [data_w-1:0]  rdata_q;
    logic [data_w-1:0]  fill_word;
    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   req_tag;

    assign idx = cpu_req.addr.index;
    assign req_tag = cpu_req.addr.tag;

    assign hit = valid[idx] && (tag_mem[idx] == req_tag);
    assign fill_word = cpu_req.we ? cpu_req.wdata : mem_rdata;  // write miss allocates

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            dirty <= '0;
            evict_dirty <= 1'b0;
        end else begin
            if (fill) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= cpu_req.we;
            end else if (cpu_update && cpu_req.we) begin
                dirty[idx] <= 1'b1;
            end
            if (flush_clean) begin
                dirty[flush_index] <= 1'b0;
            end
            if (latch_victim) begin
                evict_dirty <= valid[idx] && dirty[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[idx] <= req_tag;
            data_mem[idx] <= fill_word;
            rdata_q <= fill_word;
        end
        if (cpu_update) begin
            if (cpu_req.we) begin
                data_mem[idx] <= cpu_req.wdata;
            end else begin
                rdata_q <= data_mem[idx];
            end
        end
        if (latch_victim) begin
            evict_addr <= '{tag: tag_mem[idx], index: idx};
            evict_data <= data_mem[idx];
        end
    end

    // victim on a miss, line under the counter during a flush
    assign line_dirty = wb_sel ? (valid[flush_index] && dirty[flush_index]) : evict_dirty;
    assign wb_addr = wb_sel ? addr_t'{tag: tag_mem[flush_index], index: flush_index}
                            : evict_addr;
    assign wb_data = wb_sel ? data_mem[flush_index] : evict_data;

    assign rdata = fill ? mem_rdata : rdata_q;  // miss data passes through on done

    a_fill_clean_excl: assert property (@(posedge clk) disable iff (!rst)
        !(fill && flush_clean));

endmodule

// File: design/main_memory.sv
`timescale 1ns/100ps

module main_memory
    import cache_pkg::*;
#(
    parameter int mem_latency = mem_latency_dflt
)
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          mem_req,
    output logic [data_w-1:0] mem_rdata,
    output logic              done_mem
);

    localparam int cnt_w = $clog2(mem_latency + 1);

    logic [data_w-1:0] mem [mem_words];
    logic [cnt_w-1:0]  lat_cnt;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // counts the cycles of the pending request
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lat_cnt <= '0;
        end else if (!mem_req.en || done_mem) begin
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    assign done_mem = mem_req.en && (lat_cnt == cnt_w'(mem_latency - 1));

    always_ff @(posedge clk) begin
        if (done_mem && !mem_req.rd) begin
            mem[mem_req.addr] <= mem_req.wdata;   // write lands at done
        end
    end

    assign mem_rdata = mem[mem_req.addr];

    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req.en && !done_mem |=> mem_req == $past(mem_req));

endmodule

// File: design/cache_top.sv
`timescale 1ns/100ps

module cache_top
    import cache_pkg::*;
#(
    parameter int mem_latency = mem_latency_dflt
)
(
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          cpu_req,
    input  logic              flush,
    output logic [data_w-1:0] rdata,
    output logic              done,
    output logic              idle,
    output logic              flush_done
);

    logic               hit;
    logic               line_dirty;
    logic               done_mem;
    logic               mem_en;
    logic               mem_rd;
    logic               fill;
    logic               cpu_update;
    logic               latch_victim;
    logic               flush_clean;
    logic               wb_sel;
    logic [index_w-1:0] flush_index;
    addr_t              wb_addr;
    logic [data_w-1:0]  wb_data;
    logic [data_w-1:0]  mem_rdata;
    mem_req_t           mem_req;

    cache_controller cache_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .flush        (flush),
        .hit          (hit),
        .line_dirty   (line_dirty),
        .done_mem     (done_mem),
        .mem_en       (mem_en),
        .mem_rd       (mem_rd),
        .fill         (fill),
        .cpu_update   (cpu_update),
        .latch_victim (latch_victim),
        .flush_clean  (flush_clean),
        .wb_sel       (wb_sel),
        .flush_index  (flush_index),
        .idle         (idle),
        .done         (done),
        .flush_done   (flush_done)
    );

    cache_array cache_array_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .fill         (fill),
        .cpu_update   (cpu_update),
        .latch_victim (latch_victim),
        .flush_clean  (flush_clean),
        .wb_sel       (wb_sel),
        .flush_index  (flush_index),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .line_dirty   (line_dirty),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .rdata        (rdata)
    );

    // reads fetch the requested line, writes come from the array
    assign mem_req = '{
        en:    mem_en,
        rd:    mem_rd,
        addr:  mem_rd ? cpu_req.addr : wb_addr,
        wdata: wb_data
    };

    main_memory #(
        .mem_latency (mem_latency)
    ) main_memory_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .done_mem  (done_mem)
    );

endmodule

// File: sim/tb_cache.sv
`timescale 1ns/100ps

module tb_cache
    import cache_pkg::*;
();

    localparam int mem_latency = 4;
    localparam int n_wr = 12;
    localparam int n_fl = 6;
    localparam int n_ops = 2 + 2 * n_wr + 3 + 4 * n_fl;
    localparam int n_flush = 3;
    localparam int timeout_cycles = n_ops * (2 * mem_latency + 4)
        + n_flush * 16 * (mem_latency + 2) + 200;

    logic              clk;
    logic              rst;
    cpu_req_t          cpu_req;
    logic              flush;
    logic [data_w-1:0] rdata;
    logic              done;
    logic              idle;
    logic              flush_done;

    logic [data_w-1:0] model [mem_words];   // expected memory contents
    logic [31:0]       lfsr;
    int                value_errs;
    int                proto_errs;

    cache_top #(
        .mem_latency (mem_latency)
    ) cache_top_inst (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .flush      (flush),
        .rdata      (rdata),
        .done       (done),
        .idle       (idle),
        .flush_done (flush_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(timeout_cycles * 8);
        $display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic compare_word(input string name, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
        assert (got == exp) else begin
            value_errs++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic require_cond(input logic cond, input string msg);
        assert (cond) else begin
            proto_errs++;
            $display("at %0t ns: %s", $time, msg);
        end
    endtask

    // one processor request, cycles counted from acceptance to done
    task automatic access(input logic we, input logic [addr_w-1:0] a,
                          input logic [data_w-1:0] wd, output logic [data_w-1:0] rd,
                          output int cycles);
        @(negedge clk);
        while (!idle) @(negedge clk);
        @(posedge clk);
        cpu_req <= '{req: 1'b1, we: we, addr: addr_t'(a), wdata: wd};
        @(negedge clk);   // acceptance cycle
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
        end
        rd = rdata;
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic write_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        logic [data_w-1:0] rd;
        int                cyc;
        access(1'b1, a, d, rd, cyc);
        model[a] = d;
    endtask

    task automatic read_check(input logic [addr_w-1:0] a, output int cycles);
        logic [data_w-1:0] got;
        access(1'b0, a, '0, got, cycles);
        compare_word("rdata", got, model[a]);
    endtask

    task automatic run_flush();
        int pulses;
        @(negedge clk);
        while (!idle) @(negedge clk);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        while (!flush_done) @(negedge clk);
        pulses = 1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (8) begin   // no second pulse may follow
            @(negedge clk);
            if (flush_done) pulses++;
        end
        require_cond(pulses == 1, "flush_done did not pulse exactly once");
        require_cond(idle, "idle not high after the flush");
    endtask

    task automatic after_reset();
        @(negedge clk);
        require_cond(idle, "idle low after reset");
        require_cond(!done && !flush_done, "done or flush_done high after reset");
    endtask

    task automatic miss_then_hit();
        logic [addr_w-1:0] a;
        logic [data_w-1:0] first;
        logic [data_w-1:0] second;
        int                cyc;
        a = addr_w'(rand_bits(addr_w));
        access(1'b0, a, '0, first, cyc);
        compare_word("rdata", first, '0);
        require_cond(cyc > 1, "first read of an untouched address did not miss");
        access(1'b0, a, '0, second, cyc);
        compare_word("rdata", second, model[a]);
        require_cond(cyc == 1, "hit done not one cycle after acceptance");
    endtask

    task automatic readback_writes();
        logic [addr_w-1:0] addrs [n_wr];
        int                cyc;
        for (int i = 0; i < n_wr; i++) begin
            addrs[i] = addr_w'(rand_bits(addr_w));
            write_word(addrs[i], rand_bits(data_w));
        end
        for (int i = 0; i < n_wr; i++) begin
            read_check(addrs[i], cyc);
        end
    endtask

    task automatic dirty_eviction();
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] b;
        int                cyc;
        a = addr_w'(rand_bits(addr_w));
        b = {~a[addr_w-1:index_w], a[index_w-1:0]};   // same index, other tag
        write_word(a, rand_bits(data_w));
        read_check(b, cyc);
        require_cond(cyc > 1, "read of a conflicting tag did not miss");
        read_check(a, cyc);
    endtask

    task automatic dirty_flush();
        logic [addr_w-1:0] addrs [n_fl];
        int                cyc;
        for (int i = 0; i < n_fl; i++) begin
            addrs[i] = addr_w'(rand_bits(addr_w));
            if (i == n_fl - 1) begin
                addrs[i][index_w-1:0] = '1;   // flush walk must reach the last line
            end
            write_word(addrs[i], rand_bits(data_w));
        end
        run_flush();
        for (int i = 0; i < n_fl; i++) begin
            read_check(addrs[i], cyc);
        end
        // evict each clean line so the reread comes from memory
        for (int i = 0; i < n_fl; i++) begin
            read_check({~addrs[i][addr_w-1:index_w], addrs[i][index_w-1:0]}, cyc);
            read_check(addrs[i], cyc);
        end
    endtask

    task automatic clean_flush_twice();
        run_flush();
        run_flush();
    endtask

    initial begin
        rst = 1'b0;
        flush = 1'b0;
        cpu_req = '0;
        lfsr = 32'hacb179d5;
        value_errs = 0;
        proto_errs = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = cache_top_inst.main_memory_inst.mem[i];
        end

        after_reset();
        miss_then_hit();
        readback_writes();
        dirty_eviction();
        dirty_flush();
        clean_flush_twice();

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
design/cache_pkg.sv
design/cache_controller.sv
design/cache_array.sv
design/main_memory.sv
design/cache_top.sv
sim/tb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_cache
./obj_dir/Vtb_cache | tee sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
